/* src/join_consts.svh */
// shared sizing macros for the frame join subsystem
// included by the package and by every RTL file that needs a width or count
`ifndef JOIN_CONSTS_SVH
`define JOIN_CONSTS_SVH

`define JOIN_DATA_W     8
`define JOIN_TAG_W      16
`define JOIN_PORTS      4
`define JOIN_FIFO_DEPTH 16
`define JOIN_LEN_W      16

`endif

/* src/join_pkg.sv */
// types shared by the joiner, FIFO, statistics stage and testbench
// referenced by scoped name, widths come from the consts header
`include "join_consts.svh"

package join_pkg;

    // one stream beat as stored in the FIFO
    typedef struct packed {
        logic [`JOIN_DATA_W-1:0] data;
        logic                    last;
        logic                    user;
    } beat_t;

    // tag sent at the head of every joined frame, high byte first
    typedef logic [`JOIN_TAG_W-1:0] tag_t;

    // output beats per frame, tag bytes included
    typedef logic [`JOIN_LEN_W-1:0] len_t;

endpackage

/* src/axis_fifo.sv */
// synchronous first-word-fall-through FIFO, payload type set by parameter
// head entry is presented whenever the FIFO holds data
`timescale 1ns/100ps
`include "join_consts.svh"

module axis_fifo #(
    parameter type T     = join_pkg::beat_t,
    parameter int  DEPTH = `JOIN_FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,

    input  T     in_beat,
    input  logic in_valid,
    output logic in_ready,

    output T     out_beat,
    output logic out_valid,
    input  logic out_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr, do_rd;

    // readiness depends on occupancy only
    assign in_ready  = (count != FULL_CNT);
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    assign do_wr = in_valid && in_ready;
    assign do_rd = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/frame_stats.sv */
// output register stage that also measures each frame
// reports beat count and error flag with a one-cycle frame_done pulse
`timescale 1ns/100ps
`include "join_consts.svh"

module frame_stats (
    input  logic                    clk,
    input  logic                    rst,

    input  join_pkg::beat_t         in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,

    output logic [`JOIN_DATA_W-1:0] out_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    out_last,
    output logic                    out_user,

    output logic                    frame_done,
    output join_pkg::len_t          frame_len,
    output logic                    frame_err
);

    join_pkg::len_t beat_cnt;
    logic           err_acc;
    logic           load, xfer;

    // one-entry stage, free when empty or draining this cycle
    assign in_ready = ~out_valid | out_ready;
    assign load     = in_valid && in_ready;
    assign xfer     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_beat.data;
            out_last <= in_beat.last;
            out_user <= in_beat.user;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid  <= 1'b0;
            beat_cnt   <= '0;
            err_acc    <= 1'b0;
            frame_done <= 1'b0;
            frame_len  <= '0;
            frame_err  <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (xfer) begin
                if (out_last) begin
                    // frame complete, publish and restart the counters
                    frame_len  <= beat_cnt + 1'b1;
                    frame_err  <= err_acc | out_user;
                    frame_done <= 1'b1;
                    beat_cnt   <= '0;
                    err_acc    <= 1'b0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                    err_acc  <= err_acc | out_user;
                end
            end
        end
    end

endmodule

/* src/axis_frame_join.sv */
// four-port tagged frame joiner with a registered skid output stage
// sends the tag, then the frames of ports 0 to 3 as one output frame
`timescale 1ns/100ps
`include "join_consts.svh"

module axis_frame_join (
    input  logic                    clk,
    input  logic                    rst,

    input  logic [`JOIN_DATA_W-1:0] in_0_data,
    input  logic                    in_0_valid,
    output logic                    in_0_ready,
    input  logic                    in_0_last,
    input  logic                    in_0_user,

    input  logic [`JOIN_DATA_W-1:0] in_1_data,
    input  logic                    in_1_valid,
    output logic                    in_1_ready,
    input  logic                    in_1_last,
    input  logic                    in_1_user,

    input  logic [`JOIN_DATA_W-1:0] in_2_data,
    input  logic                    in_2_valid,
    output logic                    in_2_ready,
    input  logic                    in_2_last,
    input  logic                    in_2_user,

    input  logic [`JOIN_DATA_W-1:0] in_3_data,
    input  logic                    in_3_valid,
    output logic                    in_3_ready,
    input  logic                    in_3_last,
    input  logic                    in_3_user,

    input  join_pkg::tag_t          tag,

    output logic [`JOIN_DATA_W-1:0] join_data,
    output logic                    join_valid,
    input  logic                    join_ready,
    output logic                    join_last,
    output logic                    join_user,

    output logic                    busy
);

    localparam int SEL_W = $clog2(`JOIN_PORTS);
    localparam logic [SEL_W-1:0] LAST_PORT = SEL_W'(`JOIN_PORTS - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_TAG,
        S_XFER
    } state_t;

    state_t state, state_next;
    logic             tag_ptr, tag_ptr_next;
    logic [SEL_W-1:0] port_sel, port_sel_next;
    logic             user_acc, user_acc_next;
    logic [`JOIN_PORTS-1:0] in_rdy, in_rdy_next;

    // gathered input ports, indexed by port_sel
    logic [`JOIN_DATA_W-1:0] p_data [`JOIN_PORTS];
    logic [`JOIN_PORTS-1:0]  p_valid, p_last, p_user;

    // beat handed from the FSM to the output stage
    logic [`JOIN_DATA_W-1:0] int_data;
    logic                    int_valid, int_last, int_user;
    logic                    out_ready_int, out_ready_early;

    // output and skid registers
    logic [`JOIN_DATA_W-1:0] join_data_reg, tmp_data_reg;
    logic join_valid_reg, join_last_reg, join_user_reg;
    logic tmp_valid_reg, tmp_last_reg, tmp_user_reg;
    logic join_valid_next, tmp_valid_next;
    logic load_out, load_tmp, tmp_to_out;

    assign p_data[0] = in_0_data;
    assign p_data[1] = in_1_data;
    assign p_data[2] = in_2_data;
    assign p_data[3] = in_3_data;
    assign p_valid   = {in_3_valid, in_2_valid, in_1_valid, in_0_valid};
    assign p_last    = {in_3_last, in_2_last, in_1_last, in_0_last};
    assign p_user    = {in_3_user, in_2_user, in_1_user, in_0_user};

    assign in_0_ready = in_rdy[0];
    assign in_1_ready = in_rdy[1];
    assign in_2_ready = in_rdy[2];
    assign in_3_ready = in_rdy[3];

    always_comb begin
        state_next    = state;
        tag_ptr_next  = tag_ptr;
        port_sel_next = port_sel;
        user_acc_next = user_acc;
        in_rdy_next   = '0;
        int_data      = '0;
        int_valid     = 1'b0;
        int_last      = 1'b0;
        int_user      = 1'b0;

        case (state)
            S_IDLE: begin
                tag_ptr_next  = 1'b0;
                port_sel_next = '0;
                user_acc_next = 1'b0;
                if (in_0_valid) begin
                    state_next = S_TAG;
                    // first tag byte goes out right away if the stage has room
                    if (out_ready_int) begin
                        tag_ptr_next = 1'b1;
                        int_data     = tag[`JOIN_TAG_W-1 -: `JOIN_DATA_W];
                        int_valid    = 1'b1;
                    end
                end
            end
            S_TAG: begin
                if (out_ready_int) begin
                    int_valid = 1'b1;
                    if (!tag_ptr) begin
                        int_data     = tag[`JOIN_TAG_W-1 -: `JOIN_DATA_W];
                        tag_ptr_next = 1'b1;
                    end else begin
                        int_data       = tag[`JOIN_DATA_W-1:0];
                        state_next     = S_XFER;
                        in_rdy_next[0] = out_ready_early;
                    end
                end
            end
            S_XFER: begin
                in_rdy_next[port_sel] = out_ready_early;
                if (p_valid[port_sel] && in_rdy[port_sel]) begin
                    int_data      = p_data[port_sel];
                    int_valid     = 1'b1;
                    user_acc_next = user_acc | p_user[port_sel];
                    if (p_last[port_sel]) begin
                        port_sel_next = port_sel + 1'b1;
                        in_rdy_next   = '0;
                        if (port_sel == LAST_PORT) begin
                            // close the joined frame with the collected error flag
                            int_last   = 1'b1;
                            int_user   = user_acc_next;
                            state_next = S_IDLE;
                        end else begin
                            in_rdy_next[port_sel_next] = out_ready_early;
                        end
                    end
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            tag_ptr  <= 1'b0;
            port_sel <= '0;
            user_acc <= 1'b0;
            in_rdy   <= '0;
            busy     <= 1'b0;
        end else begin
            state    <= state_next;
            tag_ptr  <= tag_ptr_next;
            port_sel <= port_sel_next;
            user_acc <= user_acc_next;
            in_rdy   <= in_rdy_next;
            busy     <= (state_next != S_IDLE);
        end
    end

    // room next cycle if the sink takes a beat, or if the skid register stays free
    assign out_ready_early = join_ready
                           | (~tmp_valid_reg & (~join_valid_reg | ~int_valid));

    always_comb begin
        join_valid_next = join_valid_reg;
        tmp_valid_next  = tmp_valid_reg;
        load_out        = 1'b0;
        load_tmp        = 1'b0;
        tmp_to_out      = 1'b0;
        if (out_ready_int) begin
            if (join_ready || !join_valid_reg) begin
                join_valid_next = int_valid;
                load_out        = 1'b1;
            end else begin
                // sink stalled, park the beat
                tmp_valid_next = int_valid;
                load_tmp       = 1'b1;
            end
        end else if (join_ready) begin
            join_valid_next = tmp_valid_reg;
            tmp_valid_next  = 1'b0;
            tmp_to_out      = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            join_valid_reg <= 1'b0;
            tmp_valid_reg  <= 1'b0;
            out_ready_int  <= 1'b0;
        end else begin
            join_valid_reg <= join_valid_next;
            tmp_valid_reg  <= tmp_valid_next;
            out_ready_int  <= out_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            join_data_reg <= int_data;
            join_last_reg <= int_last;
            join_user_reg <= int_user;
        end else if (tmp_to_out) begin
            join_data_reg <= tmp_data_reg;
            join_last_reg <= tmp_last_reg;
            join_user_reg <= tmp_user_reg;
        end
        if (load_tmp) begin
            tmp_data_reg <= int_data;
            tmp_last_reg <= int_last;
            tmp_user_reg <= int_user;
        end
    end

    assign join_data  = join_data_reg;
    assign join_valid = join_valid_reg;
    assign join_last  = join_last_reg;
    assign join_user  = join_user_reg;

endmodule

/* src/join_top.sv */
// top level of the frame join subsystem
// joiner feeds a FIFO, which feeds the frame statistics stage
`timescale 1ns/100ps
`include "join_consts.svh"

module join_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic [`JOIN_DATA_W-1:0] in_0_data,
    input  logic                    in_0_valid,
    output logic                    in_0_ready,
    input  logic                    in_0_last,
    input  logic                    in_0_user,

    input  logic [`JOIN_DATA_W-1:0] in_1_data,
    input  logic                    in_1_valid,
    output logic                    in_1_ready,
    input  logic                    in_1_last,
    input  logic                    in_1_user,

    input  logic [`JOIN_DATA_W-1:0] in_2_data,
    input  logic                    in_2_valid,
    output logic                    in_2_ready,
    input  logic                    in_2_last,
    input  logic                    in_2_user,

    input  logic [`JOIN_DATA_W-1:0] in_3_data,
    input  logic                    in_3_valid,
    output logic                    in_3_ready,
    input  logic                    in_3_last,
    input  logic                    in_3_user,

    input  join_pkg::tag_t          tag,

    output logic [`JOIN_DATA_W-1:0] out_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    out_last,
    output logic                    out_user,

    output logic                    busy,
    output logic                    frame_done,
    output join_pkg::len_t          frame_len,
    output logic                    frame_err
);

    logic [`JOIN_DATA_W-1:0] join_data;
    logic                    join_valid, join_ready, join_last, join_user;
    join_pkg::beat_t         join_beat, fifo_beat;
    logic                    fifo_valid, fifo_ready;

    // loose joiner outputs packed into one FIFO entry
    assign join_beat = '{data: join_data, last: join_last, user: join_user};

    axis_frame_join u_join (
        .clk        (clk),
        .rst        (rst),
        .in_0_data  (in_0_data),
        .in_0_valid (in_0_valid),
        .in_0_ready (in_0_ready),
        .in_0_last  (in_0_last),
        .in_0_user  (in_0_user),
        .in_1_data  (in_1_data),
        .in_1_valid (in_1_valid),
        .in_1_ready (in_1_ready),
        .in_1_last  (in_1_last),
        .in_1_user  (in_1_user),
        .in_2_data  (in_2_data),
        .in_2_valid (in_2_valid),
        .in_2_ready (in_2_ready),
        .in_2_last  (in_2_last),
        .in_2_user  (in_2_user),
        .in_3_data  (in_3_data),
        .in_3_valid (in_3_valid),
        .in_3_ready (in_3_ready),
        .in_3_last  (in_3_last),
        .in_3_user  (in_3_user),
        .tag        (tag),
        .join_data  (join_data),
        .join_valid (join_valid),
        .join_ready (join_ready),
        .join_last  (join_last),
        .join_user  (join_user),
        .busy       (busy)
    );

    axis_fifo #(
        .T     (join_pkg::beat_t),
        .DEPTH (`JOIN_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (join_beat),
        .in_valid  (join_valid),
        .in_ready  (join_ready),
        .out_beat  (fifo_beat),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    frame_stats u_stats (
        .clk        (clk),
        .rst        (rst),
        .in_beat    (fifo_beat),
        .in_valid   (fifo_valid),
        .in_ready   (fifo_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_last   (out_last),
        .out_user   (out_user),
        .frame_done (frame_done),
        .frame_len  (frame_len),
        .frame_err  (frame_err)
    );

endmodule

/* tb/tb_join_top.sv */
// directed testbench for the frame join subsystem
// drives the four input ports, collects the joined frame and checks beats and stats
`timescale 1ns/100ps
`include "join_consts.svh"

module tb_join_top;

    localparam int TIMEOUT = 2000;

    logic                    clk;
    logic                    rst;
    logic [`JOIN_DATA_W-1:0] in_data [`JOIN_PORTS];
    logic [`JOIN_PORTS-1:0]  in_valid, in_last, in_user;
    wire  [`JOIN_PORTS-1:0]  in_ready;
    join_pkg::tag_t          tag;
    logic [`JOIN_DATA_W-1:0] out_data;
    logic                    out_valid, out_ready, out_last, out_user;
    logic                    busy, frame_done, frame_err;
    join_pkg::len_t          frame_len;

    integer                  seed;
    logic                    gap_en;
    join_pkg::beat_t         exp_q[$];
    join_pkg::beat_t         got_q[$];
    join_pkg::len_t          last_len;
    logic                    last_err;

    join_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_0_data  (in_data[0]),
        .in_0_valid (in_valid[0]),
        .in_0_ready (in_ready[0]),
        .in_0_last  (in_last[0]),
        .in_0_user  (in_user[0]),
        .in_1_data  (in_data[1]),
        .in_1_valid (in_valid[1]),
        .in_1_ready (in_ready[1]),
        .in_1_last  (in_last[1]),
        .in_1_user  (in_user[1]),
        .in_2_data  (in_data[2]),
        .in_2_valid (in_valid[2]),
        .in_2_ready (in_ready[2]),
        .in_2_last  (in_last[2]),
        .in_2_user  (in_user[2]),
        .in_3_data  (in_data[3]),
        .in_3_valid (in_valid[3]),
        .in_3_ready (in_ready[3]),
        .in_3_last  (in_last[3]),
        .in_3_user  (in_user[3]),
        .tag        (tag),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_last   (out_last),
        .out_user   (out_user),
        .busy       (busy),
        .frame_done (frame_done),
        .frame_len  (frame_len),
        .frame_err  (frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_beat(input string name, input join_pkg::beat_t exp_b,
                              input join_pkg::beat_t act_b);
        if (act_b !== exp_b) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp_b, act_b));
        end
    endtask

    task automatic check_len(input string name, input join_pkg::len_t exp_l,
                             input join_pkg::len_t act_l);
        if (act_l !== exp_l) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp_l, act_l));
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    function automatic int rand_below(input int max);
        return $unsigned($random(seed)) % max;
    endfunction

    // bytes count up from first_byte
    // the user flag rides on the last beat only
    task automatic send_port(input int n, input int length, input logic [7:0] first_byte,
                             input logic user_flag);
        int i;
        int waited;
        for (i = 0; i < length; i++) begin
            if (gap_en) begin
                repeat (rand_below(3)) begin
                    @(negedge clk);
                    in_valid[n] = 1'b0;
                end
            end
            @(negedge clk);
            in_valid[n] = 1'b1;
            in_data[n]  = first_byte + 8'(i);
            in_last[n]  = (i == length - 1);
            in_user[n]  = user_flag && (i == length - 1);
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run($sformatf("timeout waiting for in_%0d_ready", n));
                end
            end while (!in_ready[n]);
        end
        @(negedge clk);
        in_valid[n] = 1'b0;
        in_last[n]  = 1'b0;
        in_user[n]  = 1'b0;
    endtask

    // captures one output frame, then holds the sink off for the frame_done cycle
    task automatic collect_frame(input logic rand_ready);
        int              waited;
        logic            done;
        join_pkg::beat_t b;
        got_q.delete();
        done   = 1'b0;
        waited = 0;
        while (!done) begin
            @(negedge clk);
            out_ready = rand_ready ? (rand_below(4) == 0) : 1'b1;
            @(posedge clk);
            check_bit("frame_done", 1'b0, frame_done);
            if (out_valid && out_ready) begin
                b.data = out_data;
                b.last = out_last;
                b.user = out_user;
                got_q.push_back(b);
                done   = out_last;
                waited = 0;
            end else begin
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run("timeout waiting for an output beat");
                end
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
        @(posedge clk);
        check_bit("frame_done", 1'b1, frame_done);
        last_len = frame_len;
        last_err = frame_err;
    endtask

    // tag high byte, tag low byte, then ports 0 to 3
    // port n starts at base + 16n
    task automatic build_expect(input join_pkg::tag_t t, input int l0, input int l1,
                                input int l2, input int l3, input logic [7:0] base,
                                input int err_port);
        int              lens [4];
        int              n;
        int              i;
        join_pkg::beat_t b;
        lens = '{l0, l1, l2, l3};
        exp_q.delete();
        b.last = 1'b0;
        b.user = 1'b0;
        b.data = t[15:8];
        exp_q.push_back(b);
        b.data = t[7:0];
        exp_q.push_back(b);
        for (n = 0; n < 4; n++) begin
            for (i = 0; i < lens[n]; i++) begin
                b.data = base + 8'(16 * n + i);
                exp_q.push_back(b);
            end
        end
        b      = exp_q[exp_q.size() - 1];
        b.last = 1'b1;
        b.user = (err_port >= 0);
        exp_q[exp_q.size() - 1] = b;
    endtask

    task automatic compare_frame();
        int i;
        check_len("beat count", join_pkg::len_t'(exp_q.size()),
                  join_pkg::len_t'(got_q.size()));
        for (i = 0; i < exp_q.size(); i++) begin
            check_beat($sformatf("beat %0d", i), exp_q[i], got_q[i]);
        end
        check_len("frame_len", join_pkg::len_t'(exp_q.size()), last_len);
        check_bit("frame_err", exp_q[exp_q.size() - 1].user, last_err);
    endtask

    task automatic send_frame(input join_pkg::tag_t t, input int l0, input int l1,
                              input int l2, input int l3, input logic [7:0] base,
                              input int err_port);
        @(negedge clk);
        tag = t;
        fork
            send_port(0, l0, base, err_port == 0);
            send_port(1, l1, base + 8'h10, err_port == 1);
            send_port(2, l2, base + 8'h20, err_port == 2);
            send_port(3, l3, base + 8'h30, err_port == 3);
        join
    endtask

    task automatic run_frame(input join_pkg::tag_t t, input int l0, input int l1,
                             input int l2, input int l3, input logic [7:0] base,
                             input int err_port);
        fork
            send_frame(t, l0, l1, l2, l3, base, err_port);
            collect_frame(1'b0);
        join
        build_expect(t, l0, l1, l2, l3, base, err_port);
        compare_frame();
    endtask

    task automatic wait_busy(input logic value);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("timeout waiting for busy to become %0d", value));
            end
        end while (busy !== value);
    endtask

    task automatic reset_values();
        int n;
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("busy", 1'b0, busy);
        check_bit("frame_done", 1'b0, frame_done);
        for (n = 0; n < 4; n++) begin
            check_bit($sformatf("in_%0d_ready", n), 1'b0, in_ready[n]);
        end
    endtask

    // ports 1 to 3 wait with valid high until port 0 opens the frame
    task automatic port_order();
        @(negedge clk);
        tag = 16'h0F0F;
        fork
            send_port(1, 2, 8'h60, 1'b0);
            send_port(2, 1, 8'h70, 1'b0);
            send_port(3, 3, 8'h80, 1'b0);
            begin
                repeat (10) begin
                    @(posedge clk);
                    check_bit("out_valid", 1'b0, out_valid);
                    check_bit("busy", 1'b0, busy);
                end
                send_port(0, 2, 8'h50, 1'b0);
            end
            collect_frame(1'b0);
        join
        build_expect(16'h0F0F, 2, 2, 1, 3, 8'h50, -1);
        compare_frame();
    endtask

    task automatic busy_tracking();
        fork
            begin
                send_frame(16'h5AA5, 1, 1, 1, 1, 8'hA0, -1);
                wait_busy(1'b0);
            end
            wait_busy(1'b1);
            collect_frame(1'b0);
        join
        build_expect(16'h5AA5, 1, 1, 1, 1, 8'hA0, -1);
        compare_frame();
    endtask

    // three frames back to back with input gaps and a stalling sink
    task automatic back_pressure();
        int fs;
        int fc;
        gap_en = 1'b1;
        fork
            for (fs = 0; fs < 3; fs++) begin
                send_frame(16'hC0DE + 16'(fs * 16'h1111), 2 + fs, 3, 1 + fs, 4,
                           8'(fs * 64), (fs == 1) ? 3 : -1);
            end
            for (fc = 0; fc < 3; fc++) begin
                collect_frame(1'b1);
                build_expect(16'hC0DE + 16'(fc * 16'h1111), 2 + fc, 3, 1 + fc, 4,
                             8'(fc * 64), (fc == 1) ? 3 : -1);
                compare_frame();
            end
        join
        gap_en = 1'b0;
    endtask

    initial begin
        seed      = 98947;
        gap_en    = 1'b0;
        rst       = 1'b1;
        tag       = '0;
        out_ready = 1'b0;
        in_data   = '{default: '0};
        in_valid  = '0;
        in_last   = '0;
        in_user   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_values();
        run_frame(16'hA55A, 1, 3, 2, 4, 8'h10, -1);
        port_order();
        // error flag on port 2's last beat
        run_frame(16'hE1E2, 2, 1, 2, 2, 8'h30, 2);
        busy_tracking();
        back_pressure();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+src
src/join_pkg.sv
src/axis_fifo.sv
src/frame_stats.sv
src/axis_frame_join.sv
src/join_top.sv
tb/tb_join_top.sv
